// ==== Bender.yml ====
package:
  name: vdp32x

sources:
  - design/vdp32x_pkg.sv
  - design/vdp32x_regs.sv
  - design/vdp32x_bus_decode.sv
  - design/vdp32x_cram.sv
  - design/vdp32x_frame_ram.sv
  - design/vdp32x_scan.sv
  - design/vdp32x_top.sv
  - target: test
    files:
      - test/vdp32x_clkgen.sv
      - test/vdp32x_properties.sv
      - test/tb_vdp32x.sv

// ==== build.f ====
design/vdp32x_pkg.sv
design/vdp32x_regs.sv
design/vdp32x_bus_decode.sv
design/vdp32x_cram.sv
design/vdp32x_frame_ram.sv
design/vdp32x_scan.sv
design/vdp32x_top.sv
test/vdp32x_clkgen.sv
test/vdp32x_properties.sv
test/tb_vdp32x.sv

// ==== design/vdp32x_bus_decode.sv ====
// Writes are single-cycle strobes never stalled, outputs are one cycle behind sh_wr
module vdp32x_bus_decode (
	input  logic                clk_sys,
	input  logic                RESET,
	input  vdp32x_pkg::sh_wr_t  sh_wr,
	output logic                reg_wr,
	output logic                reg_sel,
	output logic [15:0]         reg_data,
	output vdp32x_pkg::mem_wr_t cram_wr,
	output vdp32x_pkg::mem_wr_t fb_wr
);

	vdp32x_pkg::region_e                region;
	logic [1:0]                         lane;    // Lanes the SH2 drives
	logic [1:0]                         nz;      // Nonzero bytes
	logic [1:0]                         fb_be;
	logic [vdp32x_pkg::FB_ADDR_W-1:0]   fb_addr;
	logic [vdp32x_pkg::FB_ADDR_W-1:0]   cram_addr;

	assign region = vdp32x_pkg::region_e'(
		sh_wr.addr[vdp32x_pkg::SH_ADDR_W-1 -: vdp32x_pkg::REGION_W]);
	assign lane = ~sh_wr.dqm_n;
	assign nz   = {|sh_wr.data[15:8], |sh_wr.data[7:0]};

	// Byte offset to word address
	assign fb_addr = {{(vdp32x_pkg::FB_ADDR_W - vdp32x_pkg::OFS_W + 1){1'b0}},
		sh_wr.addr[vdp32x_pkg::OFS_W-1:1]};
	assign cram_addr = {{(vdp32x_pkg::FB_ADDR_W - vdp32x_pkg::CRAM_ADDR_W){1'b0}},
		sh_wr.addr[vdp32x_pkg::CRAM_ADDR_W:1]}; // Wraps at 256 entries

	// Zero byte can never be written as a byte
	always_comb begin
		if (region == vdp32x_pkg::REGION_OVR)
			fb_be = lane & nz;            // Overwrite skips every zero byte
		else if (&lane)
			fb_be = lane;                 // Word write always lands
		else
			fb_be = lane & nz;            // Single byte of zero dropped
	end

	always_ff @(posedge clk_sys or posedge RESET) begin
		if (RESET) begin
			reg_wr     <= 1'b0;
			cram_wr.en <= 1'b0;
			fb_wr.en   <= 1'b0;
		end else begin
			reg_wr     <= sh_wr.wr && (region == vdp32x_pkg::REGION_REG) && lane[0];
			cram_wr.en <= sh_wr.wr && (region == vdp32x_pkg::REGION_CRAM) && (|lane);
			fb_wr.en   <= sh_wr.wr && (region == vdp32x_pkg::REGION_FB ||
				region == vdp32x_pkg::REGION_OVR) && (|fb_be);
			// Payload
			reg_sel      <= sh_wr.addr[1];   // Offset 2 is swap
			reg_data     <= sh_wr.data;
			cram_wr.be   <= lane;
			cram_wr.addr <= cram_addr;
			cram_wr.data <= sh_wr.data;
			fb_wr.be     <= fb_be;
			fb_wr.addr   <= fb_addr;
			fb_wr.data   <= sh_wr.data;
		end
	end

endmodule

// ==== design/vdp32x_cram.sv ====
// Palette read is registered with one cycle latency, bit 15 of an entry is stored but never shown
module vdp32x_cram (
	input  logic                                clk_sys,
	input  vdp32x_pkg::mem_wr_t                 wr,
	input  logic [vdp32x_pkg::CRAM_ADDR_W-1:0]  rd_idx,
	output vdp32x_pkg::rgb555_t                 rd_color
);

	logic [15:0]                        mem [vdp32x_pkg::CRAM_DEPTH];
	logic [vdp32x_pkg::CRAM_ADDR_W-1:0] wr_idx;

	assign wr_idx = wr.addr[vdp32x_pkg::CRAM_ADDR_W-1:0]; // Upper word bits already zero

	// Bus side
	always_ff @(posedge clk_sys) begin
		if (wr.en) begin
			if (wr.be[1])
				mem[wr_idx][15:8] <= wr.data[15:8];
			if (wr.be[0])
				mem[wr_idx][7:0] <= wr.data[7:0];
		end
	end

	// Display side
	always_ff @(posedge clk_sys) begin
		rd_color <= vdp32x_pkg::rgb555_t'(mem[rd_idx][14:0]);
	end

endmodule

// ==== design/vdp32x_frame_ram.sv ====
// Two banks of 64K words, read latency 1 and a same-address write in that cycle returns old data
module vdp32x_frame_ram (
	input  logic                              clk_sys,
	input  vdp32x_pkg::mem_wr_t               wr,
	input  logic                              wr_bank,
	input  logic [vdp32x_pkg::FB_ADDR_W-1:0]  rd_addr,
	input  logic                              rd_bank,
	output logic [15:0]                       rd_data
);

	logic [15:0]                    mem [vdp32x_pkg::FB_WORDS];
	logic [vdp32x_pkg::FB_ADDR_W:0] wr_a; // Bank on top
	logic [vdp32x_pkg::FB_ADDR_W:0] rd_a;

	assign wr_a = {wr_bank, wr.addr};
	assign rd_a = {rd_bank, rd_addr};

	////////////////////////////////////////////////////////////////////////////
	// SH2 port, per byte
	always_ff @(posedge clk_sys) begin
		if (wr.en) begin
			if (wr.be[1])
				mem[wr_a][15:8] <= wr.data[15:8];
			if (wr.be[0])
				mem[wr_a][7:0] <= wr.data[7:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Scanner port
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_a];
	end

endmodule

// ==== design/vdp32x_pkg.sv ====
// One pixel per clk_sys on a 400 x 262 raster, each SH2 write region spans 64 KB of bytes
package vdp32x_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Raster
	localparam int H_TOTAL   = 400; // Cycles per line
	localparam int V_TOTAL   = 262; // Lines per frame
	localparam int HSYNC_LEN = 32;
	localparam int VSYNC_LEN = 3;
	localparam int WIN_X     = 40;  // Window origin, raster coords
	localparam int WIN_Y     = 16;
	localparam int WIN_W     = 320;
	localparam int WIN_H     = 224;

	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);
	localparam int PIX_W   = $clog2(WIN_W);     // Pixel count inside a window line
	localparam int LINE_W  = $clog2(WIN_H + 1); // Window line, may sit one past the end

	////////////////////////////////////////////////////////////////////////////
	// Memories
	localparam int FB_ADDR_W   = 16; // Word address in one bank
	localparam int FB_WORDS    = 2 ** (FB_ADDR_W + 1); // Both banks
	localparam int CRAM_DEPTH  = 256;
	localparam int CRAM_ADDR_W = $clog2(CRAM_DEPTH);

	////////////////////////////////////////////////////////////////////////////
	// SH2 write bus
	localparam int SH_ADDR_W = 18; // Byte address
	localparam int REGION_W  = 2;  // Top bits pick the target
	localparam int OFS_W     = SH_ADDR_W - REGION_W; // Byte offset inside a region

	typedef enum logic [1:0] {
		FB_BLANK,
		FB_PACKED, // Two palette indices per word
		FB_DIRECT, // 15-bit colour per word
		FB_RLE     // Length in upper byte, index in lower
	} fb_mode_e;

	typedef enum logic [1:0] {
		REGION_REG  = 2'd0, // Mode at offset 0, swap at offset 2
		REGION_CRAM = 2'd1,
		REGION_FB   = 2'd2,
		REGION_OVR  = 2'd3  // Same words as REGION_FB, zero bytes skipped
	} region_e;

	typedef struct packed {
		logic                 wr;
		logic [SH_ADDR_W-1:0] addr;
		logic [15:0]          data;
		logic [1:0]           dqm_n; // Bit 1 masks the upper byte
	} sh_wr_t;

	typedef struct packed {
		logic                 en;
		logic [1:0]           be;
		logic [FB_ADDR_W-1:0] addr; // Word address
		logic [15:0]          data;
	} mem_wr_t;

	typedef struct packed {
		fb_mode_e mode;
		logic     swap; // Bank written by the SH2, display uses the other
	} vdp_cfg_t;

	typedef struct packed {
		logic [4:0] b;
		logic [4:0] g;
		logic [4:0] r; // Red in the low bits of the colour word
	} rgb555_t;

	typedef struct packed {
		rgb555_t rgb;
		logic    hsync;
		logic    vsync;
		logic    de;
	} pix_out_t;

endpackage

// ==== design/vdp32x_regs.sv ====
// Written values reach the display only at the next frame_start pulse, swap_now follows writes at once
module vdp32x_regs (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 reg_wr,
	input  logic                 reg_sel,     // 0 mode, 1 swap
	input  logic [15:0]          reg_data,
	input  logic                 frame_start,
	output logic                 swap_now,
	output vdp32x_pkg::vdp_cfg_t cfg
);

	vdp32x_pkg::fb_mode_e mode_q; // As last written by the SH2
	logic                 swap_q;

	assign swap_now = swap_q; // Write banking switches right away

	always_ff @(posedge clk_sys or posedge RESET) begin
		if (RESET) begin
			mode_q   <= vdp32x_pkg::FB_BLANK;
			swap_q   <= 1'b0;
			cfg.mode <= vdp32x_pkg::FB_BLANK;
			cfg.swap <= 1'b0;
		end else begin
			if (reg_wr) begin
				if (reg_sel)
					swap_q <= reg_data[0];
				else
					mode_q <= vdp32x_pkg::fb_mode_e'(reg_data[1:0]);
			end
			// Whole frame renders with one mode and one bank
			if (frame_start) begin
				cfg.mode <= mode_q;
				cfg.swap <= swap_q;
			end
		end
	end

endmodule

// ==== design/vdp32x_scan.sv ====
// Pixels leave three cycles after their raster position, mode and bank must stay fixed within a frame
module vdp32x_scan (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  vdp32x_pkg::vdp_cfg_t               cfg,
	output logic                               frame_start,
	output logic [vdp32x_pkg::FB_ADDR_W-1:0]   fb_rd_addr,
	output logic                               fb_rd_bank,
	input  logic [15:0]                        fb_rd_data,
	output logic [vdp32x_pkg::CRAM_ADDR_W-1:0] cram_idx,
	input  vdp32x_pkg::rgb555_t                cram_color,
	output vdp32x_pkg::pix_out_t               pix
);

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
		logic odd; // Odd pixel of a packed word
	} ctl_t;

	logic [vdp32x_pkg::H_CNT_W-1:0]   h_cnt;
	logic [vdp32x_pkg::V_CNT_W-1:0]   v_cnt;
	logic [vdp32x_pkg::H_CNT_W-1:0]   win_x;
	logic [vdp32x_pkg::PIX_W-1:0]     pix_cnt;
	logic [vdp32x_pkg::LINE_W-1:0]    win_line;
	logic                             h_in;
	logic                             v_in;
	ctl_t                             s0;
	ctl_t                             s1;
	ctl_t                             s2;
	logic [vdp32x_pkg::FB_ADDR_W-1:0] line_start; // From the line table
	logic [vdp32x_pkg::FB_ADDR_W-1:0] pix_ofs;
	logic                             rle_on;
	logic                             run_new;
	logic [vdp32x_pkg::PIX_W-1:0]     rle_ptr;    // Word of the current run
	logic [vdp32x_pkg::PIX_W-1:0]     rle_ptr_nx;
	logic [7:0]                       run_left;   // Pixels still owed to the run
	logic [7:0]                       idx_hold;
	logic [14:0]                      direct_q;
	vdp32x_pkg::rgb555_t              rgb_nx;

	////////////////////////////////////////////////////////////////////////////
	// Stage 0 raster position and read address
	assign win_x   = h_cnt - vdp32x_pkg::WIN_X[vdp32x_pkg::H_CNT_W-1:0];
	assign pix_cnt = win_x[vdp32x_pkg::PIX_W-1:0];
	assign h_in = (h_cnt >= vdp32x_pkg::WIN_X) &&
		(h_cnt < vdp32x_pkg::WIN_X + vdp32x_pkg::WIN_W);
	assign v_in = (v_cnt >= vdp32x_pkg::WIN_Y) &&
		(v_cnt < vdp32x_pkg::WIN_Y + vdp32x_pkg::WIN_H);

	assign s0.hsync = (h_cnt < vdp32x_pkg::HSYNC_LEN);
	assign s0.vsync = (v_cnt < vdp32x_pkg::VSYNC_LEN);
	assign s0.de    = h_in && v_in;
	assign s0.odd   = pix_cnt[0];

	assign frame_start = (h_cnt == '0) && (v_cnt == '0); // Vsync rising at the raster
	assign fb_rd_bank  = ~cfg.swap; // Display the bank the SH2 is not writing

	always_comb begin
		case (cfg.mode)
			vdp32x_pkg::FB_PACKED:   // Two pixels per word
				pix_ofs = {{(vdp32x_pkg::FB_ADDR_W - vdp32x_pkg::PIX_W + 1){1'b0}},
					pix_cnt[vdp32x_pkg::PIX_W-1:1]};
			vdp32x_pkg::FB_RLE:      // Run word chosen by stage 1
				pix_ofs = {{(vdp32x_pkg::FB_ADDR_W - vdp32x_pkg::PIX_W){1'b0}}, rle_ptr_nx};
			default:
				pix_ofs = {{(vdp32x_pkg::FB_ADDR_W - vdp32x_pkg::PIX_W){1'b0}}, pix_cnt};
		endcase
	end

	// Line table word outside the window
	assign fb_rd_addr = s0.de ? (line_start + pix_ofs) :
		{{(vdp32x_pkg::FB_ADDR_W - vdp32x_pkg::LINE_W){1'b0}}, win_line};

	always_ff @(posedge clk_sys or posedge RESET) begin
		if (RESET) begin
			h_cnt    <= '0;
			v_cnt    <= '0;
			win_line <= '0;
		end else begin
			if (h_cnt == vdp32x_pkg::H_TOTAL - 1) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == vdp32x_pkg::V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
			if (frame_start)
				win_line <= '0;
			else if (s0.de && h_cnt == vdp32x_pkg::WIN_X + vdp32x_pkg::WIN_W - 1)
				win_line <= win_line + 1'b1; // Last pixel of a window line
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 frame buffer word in hand
	assign rle_on  = s1.de && (cfg.mode == vdp32x_pkg::FB_RLE);
	assign run_new = (run_left == 8'd0);

	// Next pixel fetches the following run word once this one is taken
	always_comb begin
		if (!rle_on)
			rle_ptr_nx = '0;
		else if (run_new)
			rle_ptr_nx = rle_ptr + 1'b1;
		else
			rle_ptr_nx = rle_ptr;
	end

	always_comb begin
		case (cfg.mode)
			vdp32x_pkg::FB_PACKED:
				cram_idx = s1.odd ? fb_rd_data[7:0] : fb_rd_data[15:8]; // Upper byte first
			vdp32x_pkg::FB_RLE:
				cram_idx = run_new ? fb_rd_data[7:0] : idx_hold;
			default:
				cram_idx = fb_rd_data[7:0];
		endcase
	end

	always_ff @(posedge clk_sys or posedge RESET) begin
		if (RESET) begin
			s1       <= '0;
			rle_ptr  <= '0;
			run_left <= '0;
		end else begin
			s1      <= s0;
			rle_ptr <= rle_ptr_nx;
			if (!rle_on)
				run_left <= '0;
			else if (run_new)
				run_left <= fb_rd_data[15:8]; // Length+1 pixels in all
			else
				run_left <= run_left - 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!s1.de)
			line_start <= fb_rd_data; // Table word of the coming line
		idx_hold <= cram_idx;
		direct_q <= fb_rd_data[14:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 colour select and output register
	always_comb begin
		if (!s2.de) begin
			rgb_nx = '0;
		end else begin
			case (cfg.mode)
				vdp32x_pkg::FB_DIRECT: rgb_nx = vdp32x_pkg::rgb555_t'(direct_q);
				vdp32x_pkg::FB_PACKED: rgb_nx = cram_color;
				vdp32x_pkg::FB_RLE:    rgb_nx = cram_color;
				default:               rgb_nx = '0; // Blank
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge RESET) begin
		if (RESET) begin
			s2  <= '0;
			pix <= '0;
		end else begin
			s2        <= s1;
			pix.hsync <= s2.hsync;
			pix.vsync <= s2.vsync;
			pix.de    <= s2.de;
			pix.rgb   <= rgb_nx;
		end
	end

endmodule

// ==== design/vdp32x_top.sv ====
// Single clock domain, SH2 writes are never stalled and there is no read path
module vdp32x_top (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  vdp32x_pkg::sh_wr_t   sh_wr,
	output vdp32x_pkg::pix_out_t pix
);

	logic                                 reg_wr;
	logic                                 reg_sel;
	logic [15:0]                          reg_data;
	vdp32x_pkg::mem_wr_t                  cram_wr;
	vdp32x_pkg::mem_wr_t                  fb_wr;
	logic                                 swap_now;    // Write bank
	vdp32x_pkg::vdp_cfg_t                 cfg;         // Frame-latched
	logic                                 frame_start;
	logic [vdp32x_pkg::FB_ADDR_W-1:0]     fb_rd_addr;
	logic                                 fb_rd_bank;
	logic [15:0]                          fb_rd_data;
	logic [vdp32x_pkg::CRAM_ADDR_W-1:0]   cram_idx;
	vdp32x_pkg::rgb555_t                  cram_color;

	////////////////////////////////////////////////////////////////////////////
	// Write side
	vdp32x_bus_decode u_bus_decode (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.sh_wr    (sh_wr),
		.reg_wr   (reg_wr),
		.reg_sel  (reg_sel),
		.reg_data (reg_data),
		.cram_wr  (cram_wr),
		.fb_wr    (fb_wr)
	);

	vdp32x_regs u_regs (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.reg_wr      (reg_wr),
		.reg_sel     (reg_sel),
		.reg_data    (reg_data),
		.frame_start (frame_start),
		.swap_now    (swap_now),
		.cfg         (cfg)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memories and display
	vdp32x_cram u_cram (
		.clk_sys  (clk_sys),
		.wr       (cram_wr),
		.rd_idx   (cram_idx),
		.rd_color (cram_color)
	);

	vdp32x_frame_ram u_frame_ram (
		.clk_sys (clk_sys),
		.wr      (fb_wr),
		.wr_bank (swap_now),
		.rd_addr (fb_rd_addr),
		.rd_bank (fb_rd_bank),
		.rd_data (fb_rd_data)
	);

	vdp32x_scan u_scan (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cfg         (cfg),
		.frame_start (frame_start),
		.fb_rd_addr  (fb_rd_addr),
		.fb_rd_bank  (fb_rd_bank),
		.fb_rd_data  (fb_rd_data),
		.cram_idx    (cram_idx),
		.cram_color  (cram_color),
		.pix         (pix)
	);

endmodule

// ==== test/tb_vdp32x.sv ====
// Writes land in the bank chosen by swap, so each test fills that bank and then flips swap
module tb_vdp32x;

	localparam int CYCLE_LIMIT = 1500000; // About 12 frames plus the write bursts
	localparam int BANK_WORDS  = 65536;

	logic                 clk_sys;
	logic                 RESET;
	vdp32x_pkg::sh_wr_t   sh_wr;
	vdp32x_pkg::pix_out_t pix;

	// Reference model
	logic [15:0]          fb_m [2 * BANK_WORDS];
	logic [15:0]          cram_m [vdp32x_pkg::CRAM_DEPTH];
	vdp32x_pkg::fb_mode_e mode_m;
	logic                 swap_m;
	logic [14:0]          line_exp [vdp32x_pkg::WIN_W];

	int cyc;
	int vs_rises; // Frame starts seen on the output
	int mark;

	vdp32x_clkgen u_clkgen (
		.clk_sys (clk_sys),
		.RESET   (RESET)
	);

	vdp32x_top u_dut (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.sh_wr   (sh_wr),
		.pix     (pix)
	);

	////////////////////////////////////////////////////////////////////////////
	// Failure paths

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	always @(posedge clk_sys) begin
		cyc++;
		if (cyc >= CYCLE_LIMIT)
			stop_run("Timeout, the frame sequence did not complete in time");
	end

	always @(posedge pix.vsync)
		vs_rises++;

	////////////////////////////////////////////////////////////////////////////
	// Bus writes and the model's byte rules

	task automatic model_write(input logic [17:0] addr, input logic [15:0] data,
		input logic [1:0] dqm_n);
		logic [1:0] lane;
		logic [1:0] be;
		int         a;
		lane = ~dqm_n;
		case (addr[17:16])
			2'd0: if (lane[0]) begin
				if (addr[1])
					swap_m = data[0];
				else
					mode_m = vdp32x_pkg::fb_mode_e'(data[1:0]);
			end
			2'd1: begin
				a = addr[8:1]; // Palette wraps at 256
				if (lane[1]) cram_m[a][15:8] = data[15:8];
				if (lane[0]) cram_m[a][7:0] = data[7:0];
			end
			default: begin
				if (addr[17:16] == 2'd3 || lane != 2'b11)
					be = lane & {data[15:8] != 0, data[7:0] != 0}; // Zero bytes skipped
				else
					be = lane;                                     // Full word lands
				a = swap_m * BANK_WORDS + addr[15:1];
				if (be[1]) fb_m[a][15:8] = data[15:8];
				if (be[0]) fb_m[a][7:0] = data[7:0];
			end
		endcase
	endtask

	task automatic bus_write(input logic [17:0] addr, input logic [15:0] data,
		input logic [1:0] dqm_n);
		model_write(addr, data, dqm_n);
		@(negedge clk_sys);
		sh_wr.wr    = 1'b1;
		sh_wr.addr  = addr;
		sh_wr.data  = data;
		sh_wr.dqm_n = dqm_n;
		@(negedge clk_sys);
		sh_wr.wr = 1'b0;
	endtask

	function automatic logic [17:0] fb_byte(input logic [1:0] region, input int w);
		return {region, w[14:0], 1'b0};
	endfunction

	task automatic fill_palette();
		for (int i = 0; i < vdp32x_pkg::CRAM_DEPTH; i++)
			bus_write({2'd1, 16'(i * 2)}, 16'($urandom), 2'b00);
	endtask

	// Mode first, then the swap flip that puts the new bank on screen
	task automatic set_regs(input vdp32x_pkg::fb_mode_e mode, input logic swap);
		bus_write(18'h0, {14'h0, mode}, 2'b00);
		bus_write(18'h2, {15'h0, swap}, 2'b00);
		if (vs_rises != mark)
			stop_run("Writes overran a frame start, the frame mixes two setups");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Expected pixels and frame capture

	task automatic build_line(input int y);
		int          base;
		int          start;
		int          ptr;
		int          x;
		logic [15:0] w;
		base  = (swap_m ? 0 : 1) * BANK_WORDS; // Display reads the other bank
		start = fb_m[base + y];                // Line table at word 0
		for (int i = 0; i < vdp32x_pkg::WIN_W; i++)
			line_exp[i] = '0;
		case (mode_m)
			vdp32x_pkg::FB_DIRECT:
				for (int i = 0; i < vdp32x_pkg::WIN_W; i++)
					line_exp[i] = fb_m[base + ((start + i) & 16'hffff)][14:0];
			vdp32x_pkg::FB_PACKED:
				for (int i = 0; i < vdp32x_pkg::WIN_W; i++) begin
					w = fb_m[base + ((start + i / 2) & 16'hffff)];
					line_exp[i] = cram_m[(i % 2) ? w[7:0] : w[15:8]][14:0];
				end
			vdp32x_pkg::FB_RLE: begin
				ptr = 0;
				x   = 0;
				while (x < vdp32x_pkg::WIN_W) begin
					w = fb_m[base + ((start + ptr) & 16'hffff)];
					for (int k = 0; k <= w[15:8] && x < vdp32x_pkg::WIN_W; k++) begin
						line_exp[x] = cram_m[w[7:0]][14:0];
						x++;
					end
					ptr++; // Run done, next word
				end
			end
			default: ;
		endcase
	endtask

	task automatic wait_vsync(input logic level);
		@(negedge clk_sys);
		while (pix.vsync !== level)
			@(negedge clk_sys);
	endtask

	task automatic check_frame();
		wait_vsync(1'b1);
		wait_vsync(1'b0);
		for (int y = 0; y < vdp32x_pkg::WIN_H; y++) begin
			build_line(y);
			for (int x = 0; x < vdp32x_pkg::WIN_W; x++) begin
				@(negedge clk_sys);
				while (pix.de !== 1'b1)
					@(negedge clk_sys);
				check("pix.rgb", pix.rgb, line_exp[x]);
			end
		end
		mark = vs_rises; // Following writes must finish before the next frame
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_blank();
		int   n;
		int   h;
		int   v;
		logic de_exp;
		n = 0;
		check("pix.de", pix.de, 1'b0);
		wait_vsync(1'b1); // Output now at raster (0,0)
		for (int c = 0; c < vdp32x_pkg::H_TOTAL * vdp32x_pkg::V_TOTAL; c++) begin
			h = c % vdp32x_pkg::H_TOTAL;
			v = c / vdp32x_pkg::H_TOTAL;
			de_exp = (h >= vdp32x_pkg::WIN_X) &&
				(h < vdp32x_pkg::WIN_X + vdp32x_pkg::WIN_W) &&
				(v >= vdp32x_pkg::WIN_Y) &&
				(v < vdp32x_pkg::WIN_Y + vdp32x_pkg::WIN_H);
			check("pix.hsync", pix.hsync, h < vdp32x_pkg::HSYNC_LEN);
			check("pix.vsync", pix.vsync, v < vdp32x_pkg::VSYNC_LEN);
			check("pix.de", pix.de, de_exp);
			check("pix.rgb", pix.rgb, 0);
			if (pix.de === 1'b1)
				n++;
			@(negedge clk_sys);
		end
		check("pix.vsync", pix.vsync, 1'b1); // Next frame starts on time
		check("de_count", n, vdp32x_pkg::WIN_W * vdp32x_pkg::WIN_H);
		mark = vs_rises;
	endtask

	task automatic write_direct_image();
		for (int y = 0; y < vdp32x_pkg::WIN_H; y++)
			bus_write(fb_byte(2'd2, y), 16'(256 + $urandom % 512), 2'b00);
		for (int w = 256; w < 1088; w++)
			bus_write(fb_byte(2'd2, w), 16'($urandom), 2'b00);
	endtask

	task automatic test_direct();
		write_direct_image();
		set_regs(vdp32x_pkg::FB_DIRECT, ~swap_m);
		check_frame();
	endtask

	task automatic test_packed();
		fill_palette();
		for (int y = 0; y < vdp32x_pkg::WIN_H; y++)
			bus_write(fb_byte(2'd2, y), 16'(256 + $urandom % 256), 2'b00);
		for (int w = 256; w < 672; w++)
			bus_write(fb_byte(2'd2, w), 16'($urandom), 2'b00);
		set_regs(vdp32x_pkg::FB_PACKED, ~swap_m);
		check_frame();
	endtask

	task automatic test_rle();
		logic [7:0] len;
		fill_palette();
		for (int y = 0; y < vdp32x_pkg::WIN_H; y++)
			bus_write(fb_byte(2'd2, y), 16'(256 + $urandom % 64), 2'b00);
		for (int w = 256; w < 640; w++) begin
			len = ($urandom % 16 == 0) ? 8'($urandom) : 8'($urandom % 8); // Zero included
			bus_write(fb_byte(2'd2, w), {len, 8'($urandom)}, 2'b00);
		end
		set_regs(vdp32x_pkg::FB_RLE, ~swap_m);
		check_frame();
	endtask

	task automatic test_write_rules();
		int w;
		for (int y = 0; y < vdp32x_pkg::WIN_H; y++)
			bus_write(fb_byte(2'd2, y), 16'(256 + y), 2'b00);
		for (int i = 256; i < 800; i++)
			bus_write(fb_byte(2'd2, i), 16'($urandom) | 16'h0101, 2'b00);
		for (int i = 0; i < 300; i++) begin
			w = 256 + $urandom % 544;
			case ($urandom % 5)
				0: bus_write(fb_byte(2'd2, w), {8'h00, 8'($urandom)}, 2'b01); // Upper zero
				1: bus_write(fb_byte(2'd2, w), {8'($urandom), 8'h00}, 2'b10); // Lower zero
				2: bus_write(fb_byte(2'd2, w), 16'h0000, 2'b00);
				3: bus_write(fb_byte(2'd3, w), ($urandom % 2) ? 16'h00c3 : 16'h5a00, 2'b00);
				default: bus_write(fb_byte(2'd2, w), 16'($urandom) | 16'h0101, 2'($urandom));
			endcase
		end
		set_regs(vdp32x_pkg::FB_DIRECT, ~swap_m);
		check_frame();
	endtask

	task automatic test_bank_swap();
		write_direct_image();
		set_regs(vdp32x_pkg::FB_DIRECT, swap_m); // New image stays hidden
		check_frame();
		set_regs(vdp32x_pkg::FB_DIRECT, ~swap_m);
		check_frame();
	endtask

	initial begin
		sh_wr    = '0;
		mode_m   = vdp32x_pkg::FB_BLANK;
		swap_m   = 1'b0;
		cyc      = 0;
		vs_rises = 0;
		mark     = 0;
		for (int i = 0; i < 2 * BANK_WORDS; i++)
			fb_m[i] = '0;
		for (int i = 0; i < vdp32x_pkg::CRAM_DEPTH; i++)
			cram_m[i] = '0;
		void'($urandom(32'hc2151fff));
		@(negedge clk_sys);
		while (RESET)
			@(negedge clk_sys);
		test_reset_blank();
		test_direct();
		test_packed();
		test_rle();
		test_write_rules();
		test_bank_swap();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== test/vdp32x_clkgen.sv ====
// Free-running clock of period 4, RESET high for two cycles and released on a falling edge
module vdp32x_clkgen (
	output logic clk_sys,
	output logic RESET
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // Period 4
	end

	initial begin
		RESET = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0; // Away from the sampling edge
	end

endmodule

// ==== test/vdp32x_properties.sv ====
// Checks only the pixel output of vdp32x_top, bound to every instance of it
module vdp32x_properties (
	input logic                 clk_sys,
	input logic                 RESET,
	input vdp32x_pkg::pix_out_t pix
);

	////////////////////////////////////////////////////////////////////////////
	// Output framing

	// Window never reaches into sync
	a_de_no_sync: assert property (@(posedge clk_sys) disable iff (RESET)
		pix.de |-> (!pix.hsync && !pix.vsync))
		else $error("de overlaps a sync pulse");

	a_rgb_blank: assert property (@(posedge clk_sys) disable iff (RESET)
		!pix.de |-> (pix.rgb == '0)) // Black outside the window
		else $error("rgb nonzero while de is low");

	// Output register cleared by reset
	a_reset_de: assert property (@(posedge clk_sys)
		RESET |=> !pix.de)
		else $error("de high after reset");

endmodule

bind vdp32x_top vdp32x_properties u_props (
	.clk_sys (clk_sys),
	.RESET   (RESET),
	.pix     (pix)
);
